/* project.f */
+incdir+source
source/rf_pkg.sv
source/rf_ram.sv
source/rf_forward.sv
source/alu_exec.sv
source/pipe_ctrl.sv
source/pipe_top.sv
bench/pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pipe_tb -f project.f
./obj_dir/Vpipe_tb 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
   exit 1
fi
exit 0

/* bench/pipe_tb.sv */
// testbench for the three-stage datapath with forwarding register file
// LFSR stimulus, in-order reference model, protocol and result assertions
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;

   import rf_pkg::*;

   localparam int MAX_CYCLES = 400 * 4 + 300;

   logic    clk = 1'b0;
   logic    rst;
   logic    in_valid_i;
   instr_t  in_instr_i;
   logic    in_ready_o;
   logic    out_valid_o;
   result_t out_result_o;
   logic    out_ready_i;

   logic        acc;
   logic        seen_acc;
   logic [15:0] lfsr = 16'd42536;
   logic        gaps_en;
   logic        stall_en;
   int          errors = 0;
   int          cycles = 0;
   int          acc_count = 0;
   int          out_count = 0;
   operand_t    model_rf [32];
   result_t     exp_q [$];
   result_t     exp_r;
   instr_t      acc_instr;

   pipe_top i_pipe_top (
      .clk          (clk),
      .rst          (rst),
      .in_valid_i   (in_valid_i),
      .in_instr_i   (in_instr_i),
      .in_ready_o   (in_ready_o),
      .out_valid_o  (out_valid_o),
      .out_result_o (out_result_o),
      .out_ready_i  (out_ready_i)
   );

   always #4 clk = ~clk;

   assign acc = in_valid_i & in_ready_o;

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r = {r[14:0], fb};
      end
      return r;
   endfunction

   function automatic operand_t model_alu(input instr_t ins, input operand_t a,
                                          input operand_t b);
      case (ins.op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLL:  return a << b[4:0];
         OP_MOVI: return {16'h0000, ins.imm};
         default: return '0;
      endcase
   endfunction

   function automatic instr_t make_instr(input alu_op_e op, input int rd, input int ra,
                                         input int rb, input imm_t imm);
      instr_t ins;
      ins.op  = op;
      ins.rd  = reg_addr_t'(rd);
      ins.ra  = reg_addr_t'(ra);
      ins.rb  = reg_addr_t'(rb);
      ins.imm = imm;
      return ins;
   endfunction

   // only r0 to r7, so hazards come often
   function automatic instr_t random_instr();
      logic [15:0] op_bits;
      instr_t      ins;
      op_bits = take_bits(3);
      ins.op  = (op_bits[2:0] == 3'd7) ? OP_ADD : alu_op_e'(op_bits[2:0]);
      ins.rd  = reg_addr_t'(take_bits(3));
      ins.ra  = reg_addr_t'(take_bits(3));
      ins.rb  = reg_addr_t'(take_bits(3));
      ins.imm = take_bits(16);
      return ins;
   endfunction

   task automatic set_ready();
      out_ready_i = stall_en ? (take_bits(2) != 16'd0) : 1'b1;
   endtask

   // called on a falling edge, returns on the falling edge after acceptance
   task automatic send(input instr_t ins);
      int target;
      while (gaps_en && take_bits(2) == 16'd0) begin
         in_valid_i = 1'b0;
         @(negedge clk);
         set_ready();
      end
      in_valid_i = 1'b1;
      in_instr_i = ins;
      target = acc_count + 1;
      do begin
         @(negedge clk);
         set_ready();
      end while (acc_count != target);
      in_valid_i = 1'b0;
   endtask

   // dependent chain at distances one to three, plus r0 reads and writes
   task automatic run_chain();
      send(make_instr(OP_ADD, 1, 2, 3, '0));
      send(make_instr(OP_SUB, 2, 1, 3, '0));
      send(make_instr(OP_XOR, 3, 1, 2, '0));
      send(make_instr(OP_OR, 4, 1, 3, '0));
      send(make_instr(OP_SLL, 5, 4, 2, '0));
      send(make_instr(OP_AND, 6, 5, 5, '0));
      send(make_instr(OP_ADD, 7, 0, 6, '0));
      send(make_instr(OP_ADD, 0, 1, 2, '0));
      send(make_instr(OP_ADD, 1, 0, 0, '0));
      send(make_instr(OP_MOVI, 2, 0, 0, 16'h0007));
      send(make_instr(OP_SLL, 3, 7, 2, '0));
   endtask

   // reference model, results taken in acceptance order
   always @(posedge clk) begin
      if (rst) begin
         seen_acc <= 1'b0;
      end else begin
         if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
               $display("ERROR %0t: result came out with no instruction pending", $time);
               errors++;
            end else begin
               exp_r = exp_q.pop_front();
               a_result: assert (out_result_o == exp_r) else begin
                  $display("ERROR %0t: got rd %0d data %h, expected rd %0d data %h", $time,
                           out_result_o.rd, out_result_o.data, exp_r.rd, exp_r.data);
                  errors++;
               end
            end
            out_count <= out_count + 1;
         end
         if (acc) begin
            acc_instr  = in_instr_i;
            exp_r.rd   = acc_instr.rd;
            exp_r.data = model_alu(acc_instr, model_rf[acc_instr.ra], model_rf[acc_instr.rb]);
            exp_q.push_back(exp_r);
            if (acc_instr.rd != '0) begin
               model_rf[acc_instr.rd] = exp_r.data;
            end
            seen_acc  <= 1'b1;
            acc_count <= acc_count + 1;
         end
      end
   end

   a_idle_after_reset: assert property (
      @(posedge clk) disable iff (rst)
      !seen_acc |-> (!out_valid_o && in_ready_o)
   ) else begin
      $display("ERROR %0t: output busy before the first instruction", $time);
      errors++;
   end

   a_out_hold: assert property (
      @(posedge clk) disable iff (rst)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_result_o))
   ) else begin
      $display("ERROR %0t: output result changed while held", $time);
      errors++;
   end

   a_stall_ready: assert property (
      @(posedge clk) disable iff (rst)
      (out_valid_o && !out_ready_i) |-> !in_ready_o
   ) else begin
      $display("ERROR %0t: input ready while the output is stalled", $time);
      errors++;
   end

   // two advancing edges after acceptance, the result must be valid
   a_latency: assert property (
      @(posedge clk) disable iff (rst)
      (in_ready_o && $past(in_ready_o) && $past(acc, 2)) |=> out_valid_o
   ) else begin
      $display("ERROR %0t: result not valid two cycles after acceptance", $time);
      errors++;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("timeout: the pipeline stopped returning results after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      rst         = 1'b1;
      in_valid_i  = 1'b0;
      in_instr_i  = '0;
      out_ready_i = 1'b1;
      gaps_en     = 1'b0;
      stall_en    = 1'b0;
      for (int r = 0; r < 32; r++) begin
         model_rf[r] = '0;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // r0 is written too, it must stay zero
      for (int r = 0; r < 8; r++) begin
         send(make_instr(OP_MOVI, r, 0, 0, take_bits(16)));
      end
      for (int pass = 0; pass < 2; pass++) begin
         stall_en = (pass == 1);
         run_chain();
      end
      gaps_en  = 1'b1;
      stall_en = 1'b1;
      repeat (300) send(random_instr());
      stall_en = 1'b0;
      while (out_count != acc_count) begin
         @(negedge clk);
         set_ready();
      end
      $display("run finished: %0d errors, %0d results checked", errors, out_count);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/pipe_top.sv */
// top level of the three-stage datapath
// pipeline control, forwarding register file and execute ALU
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 in_valid_i,
   input  wire rf_pkg::instr_t in_instr_i,
   output logic                in_ready_o,
   output logic                out_valid_o,
   output rf_pkg::result_t     out_result_o,
   input  wire                 out_ready_i
);

   import rf_pkg::*;

   logic     padv;
   instr_t   exec_instr;
   logic     exec_valid;
   operand_t exec_result;
   result_t  ctrl_result;
   result_t  wb_result;
   logic     exec_wb;
   logic     ctrl_wb;
   logic     wb_wb;
   operand_t exec_rfa;
   operand_t exec_rfb;

   pipe_ctrl i_pipe_ctrl (
      .clk           (clk),
      .rst           (rst),
      .in_valid_i    (in_valid_i),
      .in_instr_i    (in_instr_i),
      .in_ready_o    (in_ready_o),
      .out_valid_o   (out_valid_o),
      .out_result_o  (out_result_o),
      .out_ready_i   (out_ready_i),
      .padv_o        (padv),
      .exec_instr_o  (exec_instr),
      .exec_valid_o  (exec_valid),
      .exec_result_i (exec_result),
      .ctrl_result_o (ctrl_result),
      .wb_result_o   (wb_result),
      .exec_wb_o     (exec_wb),
      .ctrl_wb_o     (ctrl_wb),
      .wb_wb_o       (wb_wb)
   );

   // decode stage is the input port, sources read on the accepting edge
   rf_forward i_rf_forward (
      .clk           (clk),
      .rst           (rst),
      .padv_i        (padv),
      .dec_ra_i      (in_instr_i.ra),
      .dec_rb_i      (in_instr_i.rb),
      .exec_rd_i     (exec_instr.rd),
      .ctrl_rd_i     (ctrl_result.rd),
      .wb_rd_i       (wb_result.rd),
      .exec_wb_i     (exec_wb),
      .ctrl_wb_i     (ctrl_wb),
      .wb_wb_i       (wb_wb),
      .exec_result_i (exec_result),
      .ctrl_result_i (ctrl_result.data),
      .wb_result_i   (wb_result.data),
      .exec_rfa_o    (exec_rfa),
      .exec_rfb_o    (exec_rfb)
   );

   alu_exec i_alu_exec (
      .clk      (clk),
      .valid_i  (exec_valid),
      .op_i     (exec_instr.op),
      .rfa_i    (exec_rfa),
      .rfb_i    (exec_rfb),
      .imm_i    (exec_instr.imm),
      .result_o (exec_result)
   );

endmodule

`default_nettype wire

/* source/pipe_ctrl.sv */
// pipeline control with stage valid bits and the advance signal
// execute, ctrl and wb stage registers and writeback flags
// input and output stream handshakes
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   in_valid_i,
   input  wire rf_pkg::instr_t   in_instr_i,
   output logic                  in_ready_o,
   output logic                  out_valid_o,
   output rf_pkg::result_t       out_result_o,
   input  wire                   out_ready_i,
   output logic                  padv_o,
   output rf_pkg::instr_t        exec_instr_o,
   output logic                  exec_valid_o,
   input  wire rf_pkg::operand_t exec_result_i,
   output rf_pkg::result_t       ctrl_result_o,
   output rf_pkg::result_t       wb_result_o,
   output logic                  exec_wb_o,
   output logic                  ctrl_wb_o,
   output logic                  wb_wb_o
);

   import rf_pkg::*;

   logic    exec_valid;
   logic    ctrl_valid;
   logic    wb_valid;

   instr_t  exec_q;
   result_t ctrl_q;
   result_t wb_q;

   // the whole pipe freezes while a result waits at the output
   assign padv_o     = ~(wb_valid & ~out_ready_i);
   assign in_ready_o = padv_o;

   always_ff @(posedge clk) begin
      if (rst) begin
         exec_valid <= 1'b0;
         ctrl_valid <= 1'b0;
         wb_valid   <= 1'b0;
      end else if (padv_o) begin
         exec_valid <= in_valid_i;
         ctrl_valid <= exec_valid;
         wb_valid   <= ctrl_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_o) begin
         exec_q       <= in_instr_i;
         ctrl_q.rd    <= exec_q.rd;
         ctrl_q.data  <= exec_result_i;
         wb_q         <= ctrl_q;
      end
   end

   // r0 writes are dropped while the result still goes out
   assign exec_wb_o = exec_valid & (exec_q.rd != '0);
   assign ctrl_wb_o = ctrl_valid & (ctrl_q.rd != '0);
   assign wb_wb_o   = wb_valid & (wb_q.rd != '0);

   assign exec_instr_o  = exec_q;
   assign exec_valid_o  = exec_valid;
   assign ctrl_result_o = ctrl_q;
   assign wb_result_o   = wb_q;

   assign out_valid_o  = wb_valid;
   assign out_result_o = wb_q;

endmodule

`default_nettype wire

/* source/alu_exec.sv */
// execute-stage ALU, combinational
// add, sub, and, or, xor, shift left and move immediate
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
   input  wire                   clk,
   input  wire                   valid_i,
   input  wire rf_pkg::alu_op_e  op_i,
   input  wire rf_pkg::operand_t rfa_i,
   input  wire rf_pkg::operand_t rfb_i,
   input  wire rf_pkg::imm_t     imm_i,
   output rf_pkg::operand_t      result_o
);

   import rf_pkg::*;

   operand_t imm_ext;

   assign imm_ext = operand_t'(imm_i);

   always_comb begin
      case (op_i)
         OP_ADD:  result_o = rfa_i + rfb_i;
         OP_SUB:  result_o = rfa_i - rfb_i;
         OP_AND:  result_o = rfa_i & rfb_i;
         OP_OR:   result_o = rfa_i | rfb_i;
         OP_XOR:  result_o = rfa_i ^ rfb_i;
         // shift amount from low 5 bits of b
         OP_SLL:  result_o = rfa_i << rfb_i[4:0];
         OP_MOVI: result_o = imm_ext;
         default: result_o = '0;
      endcase
   end

   // bubbles may carry any op, only a valid instruction is checked
   a_op_defined: assert property (
      @(posedge clk)
      valid_i |-> (op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                OP_XOR, OP_SLL, OP_MOVI})
   ) else $error("ERROR %0t: alu_exec undefined op %0d", $time, op_i);

endmodule

`default_nettype wire

/* source/rf_forward.sv */
// register file with two RAM read copies
// hazard detection against execute, ctrl and wb destinations
// priority forwarding of results into the execute-stage operands
`timescale 1ns/1ps
`default_nettype none

module rf_forward (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    padv_i,
   input  wire rf_pkg::reg_addr_t dec_ra_i,
   input  wire rf_pkg::reg_addr_t dec_rb_i,
   input  wire rf_pkg::reg_addr_t exec_rd_i,
   input  wire rf_pkg::reg_addr_t ctrl_rd_i,
   input  wire rf_pkg::reg_addr_t wb_rd_i,
   input  wire                    exec_wb_i,
   input  wire                    ctrl_wb_i,
   input  wire                    wb_wb_i,
   input  wire rf_pkg::operand_t  exec_result_i,
   input  wire rf_pkg::operand_t  ctrl_result_i,
   input  wire rf_pkg::operand_t  wb_result_i,
   output rf_pkg::operand_t       exec_rfa_o,
   output rf_pkg::operand_t       exec_rfb_o
);

   import rf_pkg::*;

   reg_addr_t dec_addr [2];
   operand_t  ram_data [2];
   operand_t  operand [2];

   // writer results caught as the consumer enters execute
   operand_t  exec_val;
   operand_t  ctrl_val;
   operand_t  wb_val;

   logic      rf_wren;

   assign dec_addr[0] = dec_ra_i;
   assign dec_addr[1] = dec_rb_i;

   // write lands on the same edge as the output handshake
   assign rf_wren = wb_wb_i & padv_i;

   always_ff @(posedge clk) begin
      if (padv_i) begin
         exec_val <= exec_result_i;
         ctrl_val <= ctrl_result_i;
         wb_val   <= wb_result_i;
      end
   end

   for (genvar p = 0; p < 2; p++) begin : g_port
      logic       exec_hz;
      logic       ctrl_hz;
      logic       wb_hz;
      logic [2:0] sel;

      rf_ram i_rf_ram (
         .clk       (clk),
         .rst       (rst),
         .rd_en_i   (padv_i),
         .rd_addr_i (dec_addr[p]),
         .rd_data_o (ram_data[p]),
         .wr_en_i   (rf_wren),
         .wr_addr_i (wb_rd_i),
         .wr_data_i (wb_result_i)
      );

      always_ff @(posedge clk) begin
         if (rst) begin
            exec_hz <= 1'b0;
            ctrl_hz <= 1'b0;
            wb_hz   <= 1'b0;
         end else if (padv_i) begin
            exec_hz <= exec_wb_i & (exec_rd_i == dec_addr[p]);
            ctrl_hz <= ctrl_wb_i & (ctrl_rd_i == dec_addr[p]);
            wb_hz   <= wb_wb_i & (wb_rd_i == dec_addr[p]);
         end
      end

      // youngest writer wins
      assign sel = {exec_hz,
                    ctrl_hz & ~exec_hz,
                    wb_hz & ~exec_hz & ~ctrl_hz};

      always_comb begin
         case (sel)
            3'b100:  operand[p] = exec_val;
            3'b010:  operand[p] = ctrl_val;
            3'b001:  operand[p] = wb_val;
            default: operand[p] = ram_data[p];
         endcase
      end
   end

   assign exec_rfa_o = operand[0];
   assign exec_rfb_o = operand[1];

endmodule

`default_nettype wire

/* source/rf_ram.sv */
// register file RAM copy, one write port and one registered read port
// read data holds while the read enable is low
`timescale 1ns/1ps
`default_nettype none

`include "rf_cfg.svh"

module rf_ram (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  rd_en_i,
   input  wire rf_pkg::reg_addr_t rd_addr_i,
   output rf_pkg::operand_t     rd_data_o,
   input  wire                  wr_en_i,
   input  wire rf_pkg::reg_addr_t wr_addr_i,
   input  wire rf_pkg::operand_t  wr_data_i
);

   import rf_pkg::*;

   operand_t mem [`RF_WORDS];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // same-edge write is not seen, old word comes out
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         if (rd_addr_i == '0) begin
            rd_data_o <= '0;
         end else begin
            rd_data_o <= mem[rd_addr_i];
         end
      end
   end

   // r0 is hardwired, the writeback flags must never target it
   a_no_r0_write: assert property (
      @(posedge clk) disable iff (rst)
      wr_en_i |-> (wr_addr_i != '0)
   ) else $error("ERROR %0t: rf_ram write to r0", $time);

endmodule

`default_nettype wire

/* source/rf_pkg.sv */
// datapath types: register number, data word, immediate
// alu operation enum, instruction and result structs
`default_nettype none

`include "rf_cfg.svh"

package rf_pkg;

   typedef logic [`RF_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [`OPERAND_WIDTH-1:0] operand_t;

   // zero-extended when used
   typedef logic [15:0] imm_t;

   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLL  = 3'd5,
      OP_MOVI = 3'd6
   } alu_op_e;

   // 34 bits
   typedef struct packed {
      alu_op_e   op;
      reg_addr_t rd;
      reg_addr_t ra;
      reg_addr_t rb;
      imm_t      imm;
   } instr_t;

   // 37 bits
   typedef struct packed {
      reg_addr_t rd;
      operand_t  data;
   } result_t;

endpackage

`default_nettype wire

/* source/rf_cfg.svh */
// width and depth defines for the register file and datapath
// shared by the package and the RAM
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// register number width
`define RF_ADDR_WIDTH 5

// number of registers, r0 reads as zero
`define RF_WORDS 32

// data word width
`define OPERAND_WIDTH 32

`endif
